// File: hw/ccip_shim_defines.svh
`ifndef CCIP_SHIM_DEFINES_SVH
`define CCIP_SHIM_DEFINES_SVH

// cache-line payload, cut down from 512.
`define CCIP_CL_DATA_WIDTH 64

`define CCIP_MMIO_DATA_WIDTH 64

// line address.
`define CCIP_ADDR_WIDTH 42

// request tag returned with every response.
`define CCIP_MDATA_WIDTH 16

// log2 of the crossing FIFO depth, 256 entries.
`define SHIM_FIFO_ADDR_WIDTH 8

// write-side fill level that raises almost-full.
`define SHIM_ALMFULL_LEVEL 128

`endif

// File: hw/ccip_shim_pkg.sv
`default_nettype none

`include "ccip_shim_defines.svh"

package ccip_shim_pkg;

   typedef logic [`CCIP_ADDR_WIDTH-1:0]      t_cl_addr;
   typedef logic [`CCIP_CL_DATA_WIDTH-1:0]   t_cl_data;
   typedef logic [`CCIP_MMIO_DATA_WIDTH-1:0] t_mmio_data;
   typedef logic [`CCIP_MDATA_WIDTH-1:0]     t_mdata;
   typedef logic [8:0]                       t_mmio_tid;

   // address plus one wrap bit.
   typedef logic [`SHIM_FIFO_ADDR_WIDTH:0]   t_fifo_ptr;

   typedef struct packed {
      logic [3:0] req_type;
      t_cl_addr   address;
      t_mdata     mdata;
   } t_c0_req_hdr;

   typedef struct packed {
      logic [3:0] req_type;
      t_cl_addr   address;
      t_mdata     mdata;
   } t_c1_req_hdr;

   typedef struct packed {
      t_mmio_tid tid;
   } t_c2_rsp_hdr;

   typedef struct packed {
      logic [3:0] resp_type;
      t_mdata     mdata;
   } t_c0_rsp_hdr;

   typedef struct packed {
      logic [3:0] resp_type;
      t_mdata     mdata;
   } t_c1_rsp_hdr;

   typedef struct packed {
      logic        valid;
      t_c0_req_hdr hdr;
   } t_c0_tx;

   typedef struct packed {
      logic        valid;
      t_c1_req_hdr hdr;
      t_cl_data    data;
   } t_c1_tx;

   typedef struct packed {
      logic        mmio_rd_valid;
      t_c2_rsp_hdr hdr;
      t_mmio_data  data;
   } t_c2_tx;

   // memory read response or MMIO request.
   typedef struct packed {
      t_c0_rsp_hdr hdr;
      t_cl_data    data;
      logic        rsp_valid;
      logic        mmio_rd_valid;
      logic        mmio_wr_valid;
   } t_c0_rx;

   typedef struct packed {
      t_c1_rsp_hdr hdr;
      logic        rsp_valid;
   } t_c1_rx;

   typedef struct packed {
      t_c0_tx c0;
      t_c1_tx c1;
      t_c2_tx c2;
   } t_if_tx;

   typedef struct packed {
      logic   c0_tx_alm_full;
      logic   c1_tx_alm_full;
      t_c0_rx c0;
      t_c1_rx c1;
   } t_if_rx;

endpackage

`default_nettype wire

// File: hw/shim_afifo.sv
`default_nettype none

`include "ccip_shim_defines.svh"

module shim_afifo #(
   parameter int WIDTH = 8
) (
   input  wire                       wr_clk,
   input  wire                       wr_rst,
   input  wire                       wr_en,
   input  wire [WIDTH-1:0]           wr_data,
   input  wire                       rd_clk,
   input  wire                       rd_rst,
   input  wire                       rd_en,
   output logic [WIDTH-1:0]          rd_data,
   output logic                      rd_empty,
   output ccip_shim_pkg::t_fifo_ptr  wr_used
);

   import ccip_shim_pkg::*;

   localparam int AW    = `SHIM_FIFO_ADDR_WIDTH;
   localparam int DEPTH = 1 << AW;

   logic [WIDTH-1:0] mem [DEPTH];

   t_fifo_ptr wr_bin;
   t_fifo_ptr wr_bin_next;
   t_fifo_ptr wr_gray;
   t_fifo_ptr rd_gray_s1;
   t_fifo_ptr rd_gray_s2;
   t_fifo_ptr rd_bin_wr;
   logic      wr_full;
   logic      wr_push;

   t_fifo_ptr rd_bin;
   t_fifo_ptr rd_bin_next;
   t_fifo_ptr rd_gray;
   t_fifo_ptr wr_gray_s1;
   t_fifo_ptr wr_gray_s2;
   logic      rd_pop;

   function automatic t_fifo_ptr bin2gray(input t_fifo_ptr b);
      return b ^ (b >> 1);
   endfunction

   function automatic t_fifo_ptr gray2bin(input t_fifo_ptr g);
      t_fifo_ptr b;
      b[AW] = g[AW];
      for (int i = AW - 1; i >= 0; i--) begin
         b[i] = b[i + 1] ^ g[i];
      end
      return b;
   endfunction

   // write side.
   assign rd_bin_wr   = gray2bin(rd_gray_s2);
   assign wr_used     = wr_bin - rd_bin_wr;
   assign wr_full     = wr_used[AW];
   assign wr_push     = wr_en & ~wr_full;
   assign wr_bin_next = wr_bin + 1'b1;

   always_ff @(posedge wr_clk) begin
      if (wr_rst) begin
         wr_bin     <= '0;
         wr_gray    <= '0;
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end else begin
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
         if (wr_push) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= bin2gray(wr_bin_next);
         end
      end
   end

   always_ff @(posedge wr_clk) begin
      if (wr_push) begin
         mem[wr_bin[AW-1:0]] <= wr_data;
      end
   end

   // read side.
   assign rd_empty    = (rd_gray == wr_gray_s2);
   assign rd_pop      = rd_en & ~rd_empty;
   assign rd_bin_next = rd_bin + 1'b1;

   always_ff @(posedge rd_clk) begin
      if (rd_rst) begin
         rd_bin     <= '0;
         rd_gray    <= '0;
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
      end else begin
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
         if (rd_pop) begin
            rd_bin  <= rd_bin_next;
            rd_gray <= bin2gray(rd_bin_next);
         end
      end
   end

   always_ff @(posedge rd_clk) begin
      if (rd_pop) begin
         rd_data <= mem[rd_bin[AW-1:0]];
      end
   end

endmodule

`default_nettype wire

// File: hw/shim_req_xing.sv
`default_nettype none

`include "ccip_shim_defines.svh"

module shim_req_xing #(
   parameter int WIDTH          = 8,
   parameter int EXTRA_PIPELINE = 1
) (
   input  wire              src_clk,
   input  wire              src_rst,
   input  wire              src_valid,
   input  wire [WIDTH-1:0]  src_data,
   input  wire              dst_clk,
   input  wire              dst_rst,
   input  wire              dst_alm_full,
   output logic             dst_valid,
   output logic [WIDTH-1:0] dst_data,
   output logic             src_alm_full
);

   import ccip_shim_pkg::*;

   logic [WIDTH-1:0] rd_data;
   logic             rd_empty;
   logic             rd_empty_q;
   logic             rd_en;
   logic             rd_valid;
   t_fifo_ptr        wr_used;

   shim_afifo #(
      .WIDTH (WIDTH)
   ) u_fifo (
      .wr_clk   (src_clk),
      .wr_rst   (src_rst),
      .wr_en    (src_valid),
      .wr_data  (src_data),
      .rd_clk   (dst_clk),
      .rd_rst   (dst_rst),
      .rd_en    (rd_en),
      .rd_data  (rd_data),
      .rd_empty (rd_empty),
      .wr_used  (wr_used)
   );

   // empty flag optionally retimed to shorten the read-enable path.
   generate
      if (EXTRA_PIPELINE == 1) begin : g_empty_reg
         always_ff @(posedge dst_clk) begin
            if (dst_rst) begin
               rd_empty_q <= 1'b1;
            end else begin
               rd_empty_q <= rd_empty;
            end
         end
      end else begin : g_empty_comb
         always_comb rd_empty_q = rd_empty;
      end
   endgenerate

   // hold off while the platform is almost full.
   assign rd_en = ~dst_alm_full & ~rd_empty_q;

   always_ff @(posedge dst_clk) begin
      if (dst_rst) begin
         rd_valid  <= 1'b0;
         dst_valid <= 1'b0;
      end else begin
         rd_valid  <= rd_en & ~rd_empty;
         dst_valid <= rd_valid;
      end
   end

   always_ff @(posedge dst_clk) begin
      dst_data <= rd_valid ? rd_data : '0;
   end

   always_ff @(posedge src_clk) begin
      if (src_rst) begin
         src_alm_full <= 1'b0;
      end else begin
         src_alm_full <= (wr_used >= `SHIM_ALMFULL_LEVEL);
      end
   end

endmodule

`default_nettype wire

// File: hw/shim_drain_xing.sv
`default_nettype none

module shim_drain_xing #(
   parameter int WIDTH = 8
) (
   input  wire              src_clk,
   input  wire              src_rst,
   input  wire              src_valid,
   input  wire [WIDTH-1:0]  src_data,
   input  wire              dst_clk,
   input  wire              dst_rst,
   output logic             dst_valid,
   output logic [WIDTH-1:0] dst_data
);

   logic [WIDTH-1:0] rd_data;
   logic             rd_empty;
   logic             rd_en;
   logic             rd_valid;

   shim_afifo #(
      .WIDTH (WIDTH)
   ) u_fifo (
      .wr_clk   (src_clk),
      .wr_rst   (src_rst),
      .wr_en    (src_valid),
      .wr_data  (src_data),
      .rd_clk   (dst_clk),
      .rd_rst   (dst_rst),
      .rd_en    (rd_en),
      .rd_data  (rd_data),
      .rd_empty (rd_empty),
      .wr_used  ()
   );

   // no flow control toward the far side.
   assign rd_en = ~rd_empty;

   always_ff @(posedge dst_clk) begin
      if (dst_rst) begin
         rd_valid  <= 1'b0;
         dst_valid <= 1'b0;
      end else begin
         rd_valid  <= rd_en;
         dst_valid <= rd_valid;
      end
   end

   always_ff @(posedge dst_clk) begin
      dst_data <= rd_valid ? rd_data : '0;
   end

endmodule

`default_nettype wire

// File: hw/ccip_async_shim.sv
`default_nettype none

module ccip_async_shim #(
   parameter int EXTRA_PIPELINE = 1
) (
   input  wire                     bb_clk,
   input  wire                     afu_softreset,
   output ccip_shim_pkg::t_if_tx   bb_tx,
   input  wire ccip_shim_pkg::t_if_rx bb_rx,
   input  wire                     afu_clk,
   output logic                    afu_reset_sync,
   input  wire ccip_shim_pkg::t_if_tx afu_tx,
   output ccip_shim_pkg::t_if_rx   afu_rx
);

   import ccip_shim_pkg::*;

   localparam int C0TX_W = $bits(t_c0_req_hdr);
   localparam int C1TX_W = $bits(t_c1_req_hdr) + $bits(t_cl_data);
   localparam int C2TX_W = $bits(t_c2_rsp_hdr) + $bits(t_mmio_data);
   localparam int C0RX_W = $bits(t_c0_rx);
   localparam int C1RX_W = $bits(t_c1_rsp_hdr);

   logic rst_sync_q1;
   logic rst_sync_q2;

   // platform reset into the afu domain.
   always_ff @(posedge afu_clk) begin
      rst_sync_q1    <= afu_softreset;
      rst_sync_q2    <= rst_sync_q1;
      afu_reset_sync <= rst_sync_q2;
   end

   t_c0_req_hdr       c0tx_hdr;
   logic              c0tx_valid;
   logic              c0tx_alm_full;
   logic [C1TX_W-1:0] c1tx_dout;
   logic              c1tx_valid;
   logic              c1tx_alm_full;
   logic [C2TX_W-1:0] c2tx_dout;
   logic              c2tx_valid;
   t_c0_rx            c0rx_item;
   logic              c0rx_wr;
   logic              c0rx_valid;
   t_c1_rsp_hdr       c1rx_hdr;
   logic              c1rx_valid;

   shim_req_xing #(
      .WIDTH          (C0TX_W),
      .EXTRA_PIPELINE (EXTRA_PIPELINE)
   ) u_c0tx (
      .src_clk      (afu_clk),
      .src_rst      (afu_reset_sync),
      .src_valid    (afu_tx.c0.valid),
      .src_data     (afu_tx.c0.hdr),
      .dst_clk      (bb_clk),
      .dst_rst      (afu_softreset),
      .dst_alm_full (bb_rx.c0_tx_alm_full),
      .dst_valid    (c0tx_valid),
      .dst_data     (c0tx_hdr),
      .src_alm_full (c0tx_alm_full)
   );

   shim_req_xing #(
      .WIDTH          (C1TX_W),
      .EXTRA_PIPELINE (EXTRA_PIPELINE)
   ) u_c1tx (
      .src_clk      (afu_clk),
      .src_rst      (afu_reset_sync),
      .src_valid    (afu_tx.c1.valid),
      .src_data     ({afu_tx.c1.hdr, afu_tx.c1.data}),
      .dst_clk      (bb_clk),
      .dst_rst      (afu_softreset),
      .dst_alm_full (bb_rx.c1_tx_alm_full),
      .dst_valid    (c1tx_valid),
      .dst_data     (c1tx_dout),
      .src_alm_full (c1tx_alm_full)
   );

   shim_drain_xing #(
      .WIDTH (C2TX_W)
   ) u_c2tx (
      .src_clk   (afu_clk),
      .src_rst   (afu_reset_sync),
      .src_valid (afu_tx.c2.mmio_rd_valid),
      .src_data  ({afu_tx.c2.hdr, afu_tx.c2.data}),
      .dst_clk   (bb_clk),
      .dst_rst   (afu_softreset),
      .dst_valid (c2tx_valid),
      .dst_data  (c2tx_dout)
   );

   // the three c0 flags ride along with the item.
   assign c0rx_wr = bb_rx.c0.rsp_valid | bb_rx.c0.mmio_rd_valid | bb_rx.c0.mmio_wr_valid;

   shim_drain_xing #(
      .WIDTH (C0RX_W)
   ) u_c0rx (
      .src_clk   (bb_clk),
      .src_rst   (afu_softreset),
      .src_valid (c0rx_wr),
      .src_data  (bb_rx.c0),
      .dst_clk   (afu_clk),
      .dst_rst   (afu_reset_sync),
      .dst_valid (c0rx_valid),
      .dst_data  (c0rx_item)
   );

   shim_drain_xing #(
      .WIDTH (C1RX_W)
   ) u_c1rx (
      .src_clk   (bb_clk),
      .src_rst   (afu_softreset),
      .src_valid (bb_rx.c1.rsp_valid),
      .src_data  (bb_rx.c1.hdr),
      .dst_clk   (afu_clk),
      .dst_rst   (afu_reset_sync),
      .dst_valid (c1rx_valid),
      .dst_data  (c1rx_hdr)
   );

   always_comb begin
      bb_tx.c0.valid         = c0tx_valid;
      bb_tx.c0.hdr           = c0tx_hdr;
      bb_tx.c1.valid         = c1tx_valid;
      {bb_tx.c1.hdr, bb_tx.c1.data} = c1tx_dout;
      bb_tx.c2.mmio_rd_valid = c2tx_valid;
      {bb_tx.c2.hdr, bb_tx.c2.data} = c2tx_dout;
   end

   always_comb begin
      afu_rx.c0_tx_alm_full   = c0tx_alm_full;
      afu_rx.c1_tx_alm_full   = c1tx_alm_full;
      afu_rx.c0.hdr           = c0rx_item.hdr;
      afu_rx.c0.data          = c0rx_item.data;
      afu_rx.c0.rsp_valid     = c0rx_valid & c0rx_item.rsp_valid;
      afu_rx.c0.mmio_rd_valid = c0rx_valid & c0rx_item.mmio_rd_valid;
      afu_rx.c0.mmio_wr_valid = c0rx_valid & c0rx_item.mmio_wr_valid;
      afu_rx.c1.hdr           = c1rx_hdr;
      afu_rx.c1.rsp_valid     = c1rx_valid;
   end

endmodule

`default_nettype wire

// File: tb/tb_shim_checker.sv
`default_nettype none

module tb_shim_checker (
   input wire                        bb_clk,
   input wire                        afu_clk,
   input wire                        afu_softreset,
   input wire                        afu_reset_sync,
   input wire ccip_shim_pkg::t_if_tx bb_tx,
   input wire ccip_shim_pkg::t_if_rx afu_rx
);

   import ccip_shim_pkg::*;

   t_c0_req_hdr c0tx_q[$];
   t_c1_tx      c1tx_q[$];
   t_c2_tx      c2tx_q[$];
   t_c0_rx      c0rx_q[$];
   t_c1_rsp_hdr c1rx_q[$];

   t_c0_req_hdr c0tx_exp;
   t_c1_tx      c1tx_exp;
   t_c2_tx      c2tx_exp;
   t_c0_rx      c0rx_exp;
   t_c1_rsp_hdr c1rx_exp;

   logic [2:0]  rst_pipe;

   int mismatch_count = 0;
   int other_count    = 0;
   int c0tx_seen      = 0;

   task automatic compare(input string name, input logic [127:0] exp, input logic [127:0] act);
      if (act !== exp) begin
         mismatch_count++;
         $display("ERROR %0t %s expected %0h actual %0h", $time, name, exp, act);
      end
   endtask

   task automatic fail(input string msg);
      other_count++;
      $display("FAIL %0t %s", $time, msg);
   endtask

   task automatic push_c0tx(input t_c0_req_hdr h);
      c0tx_q.push_back(h);
   endtask

   task automatic push_c1tx(input t_c1_tx t);
      c1tx_q.push_back(t);
   endtask

   task automatic push_c2tx(input t_c2_tx t);
      c2tx_q.push_back(t);
   endtask

   task automatic push_c0rx(input t_c0_rx r);
      c0rx_q.push_back(r);
   endtask

   task automatic push_c1rx(input t_c1_rsp_hdr h);
      c1rx_q.push_back(h);
   endtask

   function automatic int pending();
      return c0tx_q.size() + c1tx_q.size() + c2tx_q.size() + c0rx_q.size() + c1rx_q.size();
   endfunction

   function automatic int pending_c0tx();
      return c0tx_q.size();
   endfunction

   // platform reset seen through three afu_clk edges.
   always @(posedge afu_clk) begin
      rst_pipe <= {rst_pipe[1:0], afu_softreset};
   end

   // bb side outputs, sampled mid-cycle.
   always @(negedge bb_clk) begin
      if (bb_tx.c0.valid === 1'b1) begin
         c0tx_seen++;
         if (c0tx_q.size() == 0) begin
            fail("unexpected extra item on bb_tx.c0");
         end else begin
            c0tx_exp = c0tx_q.pop_front();
            compare("bb_tx.c0.hdr", c0tx_exp, bb_tx.c0.hdr);
         end
      end
      if (bb_tx.c1.valid === 1'b1) begin
         if (c1tx_q.size() == 0) begin
            fail("unexpected extra item on bb_tx.c1");
         end else begin
            c1tx_exp = c1tx_q.pop_front();
            compare("bb_tx.c1.hdr", c1tx_exp.hdr, bb_tx.c1.hdr);
            compare("bb_tx.c1.data", c1tx_exp.data, bb_tx.c1.data);
         end
      end
      if (bb_tx.c2.mmio_rd_valid === 1'b1) begin
         if (c2tx_q.size() == 0) begin
            fail("unexpected extra item on bb_tx.c2");
         end else begin
            c2tx_exp = c2tx_q.pop_front();
            compare("bb_tx.c2.hdr", c2tx_exp.hdr, bb_tx.c2.hdr);
            compare("bb_tx.c2.data", c2tx_exp.data, bb_tx.c2.data);
         end
      end
   end

   // afu side outputs.
   always @(negedge afu_clk) begin
      if (!$isunknown(rst_pipe[2])) begin
         compare("afu_reset_sync", rst_pipe[2], afu_reset_sync);
      end
      if ((afu_rx.c0.rsp_valid | afu_rx.c0.mmio_rd_valid | afu_rx.c0.mmio_wr_valid) === 1'b1) begin
         if (c0rx_q.size() == 0) begin
            fail("unexpected extra item on afu_rx.c0");
         end else begin
            c0rx_exp = c0rx_q.pop_front();
            compare("afu_rx.c0 flags",
                    {c0rx_exp.rsp_valid, c0rx_exp.mmio_rd_valid, c0rx_exp.mmio_wr_valid},
                    {afu_rx.c0.rsp_valid, afu_rx.c0.mmio_rd_valid, afu_rx.c0.mmio_wr_valid});
            compare("afu_rx.c0.hdr", c0rx_exp.hdr, afu_rx.c0.hdr);
            compare("afu_rx.c0.data", c0rx_exp.data, afu_rx.c0.data);
         end
      end
      if (afu_rx.c1.rsp_valid === 1'b1) begin
         if (c1rx_q.size() == 0) begin
            fail("unexpected extra item on afu_rx.c1");
         end else begin
            c1rx_exp = c1rx_q.pop_front();
            compare("afu_rx.c1.hdr", c1rx_exp, afu_rx.c1.hdr);
         end
      end
   end

   task automatic check_idle();
      compare("bb_tx.c0.valid", 0, bb_tx.c0.valid);
      compare("bb_tx.c1.valid", 0, bb_tx.c1.valid);
      compare("bb_tx.c2.mmio_rd_valid", 0, bb_tx.c2.mmio_rd_valid);
      compare("afu_rx.c0.rsp_valid", 0, afu_rx.c0.rsp_valid);
      compare("afu_rx.c0.mmio_rd_valid", 0, afu_rx.c0.mmio_rd_valid);
      compare("afu_rx.c0.mmio_wr_valid", 0, afu_rx.c0.mmio_wr_valid);
      compare("afu_rx.c1.rsp_valid", 0, afu_rx.c1.rsp_valid);
      compare("afu_rx.c0_tx_alm_full", 0, afu_rx.c0_tx_alm_full);
      compare("afu_rx.c1_tx_alm_full", 0, afu_rx.c1_tx_alm_full);
   endtask

   task automatic check_c0_alm(input logic exp);
      compare("afu_rx.c0_tx_alm_full", exp, afu_rx.c0_tx_alm_full);
   endtask

   task automatic check_c0_held();
      if (c0tx_seen != 0) begin
         fail($sformatf("%0d c0 requests left while the platform was almost full", c0tx_seen));
      end
   endtask

   task automatic final_check();
      if (c0tx_q.size() != 0) fail($sformatf("%0d c0 requests never arrived", c0tx_q.size()));
      if (c1tx_q.size() != 0) fail($sformatf("%0d c1 requests never arrived", c1tx_q.size()));
      if (c2tx_q.size() != 0) fail($sformatf("%0d mmio responses never arrived", c2tx_q.size()));
      if (c0rx_q.size() != 0) fail($sformatf("%0d c0 rx items never arrived", c0rx_q.size()));
      if (c1rx_q.size() != 0) fail($sformatf("%0d c1 responses never arrived", c1rx_q.size()));
   endtask

endmodule

`default_nettype wire

// File: tb/tb_ccip_async_shim.sv
`default_nettype none

module tb_ccip_async_shim;

   import ccip_shim_pkg::*;

   localparam int NUM_BP         = 140;
   localparam int NUM_MIX        = 60;
   localparam int NUM_ENTRIES    = NUM_BP + NUM_MIX;
   localparam int TIMEOUT_CYCLES = 8 * NUM_ENTRIES + 2000;

   // chan: 0 c0 tx, 1 c1 tx, 2 c2 tx, 3 c0 rx, 4 c1 rx.
   typedef struct {
      int          chan;
      logic [3:0]  typ;
      logic [41:0] addr;
      logic [15:0] mdata;
      logic [63:0] data;
      logic [2:0]  flags;
      int          gap;
      bit          bp;
   } entry_t;

   logic   bb_clk;
   logic   afu_clk;
   logic   afu_softreset;
   logic   afu_reset_sync;
   t_if_tx afu_tx;
   t_if_tx bb_tx;
   t_if_rx bb_rx;
   t_if_rx afu_rx;

   entry_t      stim [NUM_ENTRIES];
   logic [31:0] lcg_state;
   int          cycles = 0;

   ccip_async_shim #(
      .EXTRA_PIPELINE (1)
   ) DUT (
      .bb_clk         (bb_clk),
      .afu_softreset  (afu_softreset),
      .bb_tx          (bb_tx),
      .bb_rx          (bb_rx),
      .afu_clk        (afu_clk),
      .afu_reset_sync (afu_reset_sync),
      .afu_tx         (afu_tx),
      .afu_rx         (afu_rx)
   );

   tb_shim_checker chk (
      .bb_clk         (bb_clk),
      .afu_clk        (afu_clk),
      .afu_softreset  (afu_softreset),
      .afu_reset_sync (afu_reset_sync),
      .bb_tx          (bb_tx),
      .afu_rx         (afu_rx)
   );

   initial begin
      bb_clk = 1'b0;
      forever #5 bb_clk = ~bb_clk;
   end

   initial begin
      afu_clk = 1'b0;
      forever #7 afu_clk = ~afu_clk;
   end

   always @(posedge bb_clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: run still busy after %0d bb_clk cycles", TIMEOUT_CYCLES);
         $display("Done: errors found");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic build_table();
      logic [31:0] r;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         r = lcg_next();
         stim[i].bp    = (i < NUM_BP);
         stim[i].chan  = stim[i].bp ? 0 : int'(r[31:16] % 5);
         stim[i].typ   = r[3:0];
         stim[i].addr  = {r[9:0], lcg_next()};
         stim[i].mdata = i[15:0];
         stim[i].data  = {lcg_next(), lcg_next()};
         stim[i].flags = 3'b001 << (r[15:8] % 3);
         stim[i].gap   = stim[i].bp ? 0 : int'(r[7:4] % 4);
      end
   endtask

   task automatic apply_entry(input entry_t e);
      t_c0_req_hdr h0;
      t_c1_tx      t1;
      t_c2_tx      t2;
      t_c0_rx      r0;
      t_c1_rsp_hdr r1;
      case (e.chan)
         0, 1, 2: begin
            // accelerator holds while its almost-full flag is up.
            if (!e.bp) begin
               @(negedge afu_clk);
               while ((e.chan == 0 && afu_rx.c0_tx_alm_full !== 1'b0) ||
                      (e.chan == 1 && afu_rx.c1_tx_alm_full !== 1'b0)) begin
                  @(negedge afu_clk);
               end
            end
            @(posedge afu_clk);
            if (e.chan == 0) begin
               h0.req_type = e.typ;
               h0.address  = e.addr;
               h0.mdata    = e.mdata;
               afu_tx.c0.valid <= 1'b1;
               afu_tx.c0.hdr   <= h0;
               chk.push_c0tx(h0);
            end else if (e.chan == 1) begin
               t1.valid        = 1'b1;
               t1.hdr.req_type = e.typ;
               t1.hdr.address  = e.addr;
               t1.hdr.mdata    = e.mdata;
               t1.data         = e.data;
               afu_tx.c1 <= t1;
               chk.push_c1tx(t1);
            end else begin
               t2.mmio_rd_valid = 1'b1;
               t2.hdr.tid       = e.mdata[8:0];
               t2.data          = e.data;
               afu_tx.c2 <= t2;
               chk.push_c2tx(t2);
            end
            @(posedge afu_clk);
            afu_tx.c0.valid        <= 1'b0;
            afu_tx.c1.valid        <= 1'b0;
            afu_tx.c2.mmio_rd_valid <= 1'b0;
            repeat (e.gap) @(posedge afu_clk);
         end
         default: begin
            @(posedge bb_clk);
            if (e.chan == 3) begin
               r0.hdr.resp_type = e.typ;
               r0.hdr.mdata     = e.mdata;
               r0.data          = e.data;
               {r0.rsp_valid, r0.mmio_rd_valid, r0.mmio_wr_valid} = e.flags;
               bb_rx.c0 <= r0;
               chk.push_c0rx(r0);
            end else begin
               r1.resp_type = e.typ;
               r1.mdata     = e.mdata;
               bb_rx.c1.hdr       <= r1;
               bb_rx.c1.rsp_valid <= 1'b1;
               chk.push_c1rx(r1);
            end
            @(posedge bb_clk);
            bb_rx.c0           <= '0;
            bb_rx.c1.rsp_valid <= 1'b0;
            repeat (e.gap) @(posedge bb_clk);
         end
      endcase
   endtask

   initial begin
      afu_softreset        = 1'b1;
      afu_tx               = '0;
      bb_rx                = '0;
      // platform almost full before any traffic.
      bb_rx.c0_tx_alm_full = 1'b1;
      lcg_state            = 32'ha205e770;
      build_table();

      repeat (3) @(posedge bb_clk);
      afu_softreset <= 1'b0;

      // afu side still in reset here.
      wait (afu_reset_sync === 1'b1);
      @(posedge afu_clk);
      @(negedge afu_clk);
      chk.check_idle();
      wait (afu_reset_sync === 1'b0);
      @(negedge afu_clk);
      chk.check_idle();

      for (int i = 0; i < NUM_BP; i++) begin
         apply_entry(stim[i]);
      end
      repeat (2) @(posedge afu_clk);
      @(negedge afu_clk);
      chk.check_c0_alm(1'b1);
      repeat (20) @(negedge bb_clk);
      chk.check_c0_held();

      @(posedge bb_clk);
      bb_rx.c0_tx_alm_full <= 1'b0;
      @(negedge bb_clk);
      while (chk.pending_c0tx() != 0) @(negedge bb_clk);
      @(negedge afu_clk);
      chk.check_c0_alm(1'b0);

      for (int i = NUM_BP; i < NUM_ENTRIES; i++) begin
         apply_entry(stim[i]);
      end
      @(negedge bb_clk);
      while (chk.pending() != 0) @(negedge bb_clk);
      // room for any duplicate to show up.
      repeat (50) @(negedge bb_clk);
      chk.final_check();

      $display("mismatches: %0d, other failures: %0d", chk.mismatch_count, chk.other_count);
      if (chk.mismatch_count == 0 && chk.other_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
+incdir+hw
hw/ccip_shim_pkg.sv
hw/shim_afifo.sv
hw/shim_req_xing.sv
hw/shim_drain_xing.sv
hw/ccip_async_shim.sv
tb/tb_shim_checker.sv
tb/tb_ccip_async_shim.sv

// File: Makefile
TOP := tb_ccip_async_shim

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir
